//--- design/quant_consts.svh
`ifndef QUANT_CONSTS_SVH
`define QUANT_CONSTS_SVH

//////////////////////////////////////////////////
// array slice geometry
//////////////////////////////////////////////////
`define QT_COLUMN_NUM 4
`define QT_PIX_PAR 2
`define QT_PIXELS (`QT_COLUMN_NUM * `QT_PIX_PAR)
// two channels of pixels in mode_18
`define QT_LANES (2 * `QT_PIXELS)

// pixel, scale and multiplier widths
`define QT_PIX88_W 24
`define QT_PIX18_W 16
`define QT_TAIL_W 16
`define QT_RANK_W 8
`define QT_MULT_A_W 24
`define QT_MULT_B_W 16
`define QT_MULT_P_W 40
`define QT_QPIX_W 8
`define QT_ROW_W (`QT_LANES * 16)
`define QT_QROW_W (`QT_LANES * `QT_QPIX_W)

//////////////////////////////////////////////////
// scale table and register map
//////////////////////////////////////////////////
`define QT_TABLE_DEPTH 16
`define QT_TABLE_IDX_W 4
`define QT_ADDR_CTRL 12'h000
`define QT_ADDR_TAIL_BASE 12'h100
`define QT_ADDR_RANK_BASE 12'h200
`define QT_AXI_ADDR_W 12
`define QT_AXI_DATA_W 32

`endif

//--- design/quant_pkg.sv
package quant_pkg;

  //////////////////////////////////////////////////
  // precision mode
  //////////////////////////////////////////////////
  // mode_88: one channel of 24-bit pixels
  // mode_18: two channels of 16-bit pixels
  typedef enum logic {
    mode_88 = 1'b0,
    mode_18 = 1'b1
  } quant_mode_e;

  //////////////////////////////////////////////////
  // axi4-lite slave states
  //////////////////////////////////////////////////
  typedef enum logic {
    write_idle,
    write_resp
  } axil_wr_state_e;

  typedef enum logic {
    read_idle,
    read_data
  } axil_rd_state_e;

endpackage

//--- design/scale_csr_axil.sv
`timescale 1ns/1ns
`include "quant_consts.svh"

module scale_csr_axil (
  input  logic                              clk,
  input  logic                              e_tail_reset,
  // axi4-lite write channels
  input  logic [`QT_AXI_ADDR_W-1:0]         awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [`QT_AXI_DATA_W-1:0]         wdata,
  input  logic [`QT_AXI_DATA_W/8-1:0]       wstrb,
  input  logic                              wvalid,
  output logic                              wready,
  output logic [1:0]                        bresp,
  output logic                              bvalid,
  input  logic                              bready,
  // axi4-lite read channels
  input  logic [`QT_AXI_ADDR_W-1:0]         araddr,
  input  logic                              arvalid,
  output logic                              arready,
  output logic [`QT_AXI_DATA_W-1:0]         rdata,
  output logic [1:0]                        rresp,
  output logic                              rvalid,
  input  logic                              rready,
  // scale table read port for the pixel path
  input  logic [`QT_TABLE_IDX_W-1:0]        channel_idx,
  output quant_pkg::quant_mode_e            mode,
  output logic [2*`QT_TAIL_W-1:0]           tail_set,
  output logic [2*`QT_RANK_W-1:0]           rank_set
);

  localparam logic [1:0] resp_okay = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  quant_pkg::axil_wr_state_e wr_state;
  quant_pkg::axil_rd_state_e rd_state;

  // per channel pair entries
  logic [2*`QT_TAIL_W-1:0] tail_mem [`QT_TABLE_DEPTH];
  logic [2*`QT_RANK_W-1:0] rank_mem [`QT_TABLE_DEPTH];

  logic wr_fire, rd_fire;
  logic aw_ctrl, aw_tail, aw_rank;
  logic ar_ctrl, ar_tail, ar_rank;
  logic [`QT_TABLE_IDX_W-1:0] aw_idx, ar_idx;
  logic [`QT_AXI_DATA_W-1:0] rd_word;

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////
  function automatic logic is_ctrl(input logic [`QT_AXI_ADDR_W-1:0] addr);
    return (addr >> 2) == (`QT_ADDR_CTRL >> 2);
  endfunction

  // true when addr falls inside a table region starting at base
  function automatic logic in_table(input logic [`QT_AXI_ADDR_W-1:0] addr,
                                    input logic [`QT_AXI_ADDR_W-1:0] base);
    return (addr >= base) && (addr < base + 4 * `QT_TABLE_DEPTH);
  endfunction

  assign aw_ctrl = is_ctrl(awaddr);
  assign aw_tail = in_table(awaddr, `QT_ADDR_TAIL_BASE);
  assign aw_rank = in_table(awaddr, `QT_ADDR_RANK_BASE);
  assign ar_ctrl = is_ctrl(araddr);
  assign ar_tail = in_table(araddr, `QT_ADDR_TAIL_BASE);
  assign ar_rank = in_table(araddr, `QT_ADDR_RANK_BASE);
  // word index, regions are 256-byte aligned
  assign aw_idx = awaddr[`QT_TABLE_IDX_W+1:2];
  assign ar_idx = araddr[`QT_TABLE_IDX_W+1:2];

  assign wr_fire = awvalid && awready && wvalid && wready;
  assign rd_fire = arvalid && arready;

  //////////////////////////////////////////////////
  // write channel fsm
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (e_tail_reset) begin
      wr_state <= quant_pkg::write_idle;
      awready <= 1'b0;
      wready <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      case (wr_state)
        quant_pkg::write_idle: begin
          if (wr_fire) begin
            wr_state <= quant_pkg::write_resp;
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b1;
          end else begin
            awready <= 1'b1;
            wready <= 1'b1;
          end
        end
        default: begin
          // hold the response until the master takes it
          if (bready) begin
            wr_state <= quant_pkg::write_idle;
            bvalid <= 1'b0;
            awready <= 1'b1;
            wready <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= (aw_ctrl || aw_tail || aw_rank) ? resp_okay : resp_slverr;
    end
  end

  // mode and table storage, byte strobes honoured
  always_ff @(posedge clk) begin
    if (e_tail_reset) begin
      mode <= quant_pkg::mode_88;
      for (int k = 0; k < `QT_TABLE_DEPTH; k++) begin
        tail_mem[k] <= '0;
        rank_mem[k] <= '0;
      end
    end else if (wr_fire) begin
      if (aw_ctrl && wstrb[0]) begin
        mode <= quant_pkg::quant_mode_e'(wdata[0]);
      end
      for (int b = 0; b < 4; b++) begin
        if (aw_tail && wstrb[b]) begin
          tail_mem[aw_idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
      // rank entry only spans the two low bytes
      for (int b = 0; b < 2; b++) begin
        if (aw_rank && wstrb[b]) begin
          rank_mem[aw_idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // read channel fsm
  //////////////////////////////////////////////////
  always_comb begin
    rd_word = '0;
    if (ar_ctrl) begin
      rd_word[0] = mode;
    end else if (ar_tail) begin
      rd_word = tail_mem[ar_idx];
    end else if (ar_rank) begin
      rd_word[2*`QT_RANK_W-1:0] = rank_mem[ar_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (e_tail_reset) begin
      rd_state <= quant_pkg::read_idle;
      arready <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      case (rd_state)
        quant_pkg::read_idle: begin
          if (rd_fire) begin
            rd_state <= quant_pkg::read_data;
            arready <= 1'b0;
            rvalid <= 1'b1;
          end else begin
            arready <= 1'b1;
          end
        end
        default: begin
          if (rready) begin
            rd_state <= quant_pkg::read_idle;
            rvalid <= 1'b0;
            arready <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= rd_word;
      rresp <= (ar_ctrl || ar_tail || ar_rank) ? resp_okay : resp_slverr;
    end
  end

  // pixel path lookup, one cycle ahead of the row
  assign tail_set = tail_mem[channel_idx];
  assign rank_set = rank_mem[channel_idx];

endmodule

//--- design/e_scale.sv
`timescale 1ns/1ns
`include "quant_consts.svh"

module e_scale (
  input  logic                                     clk,
  input  logic                                     e_tail_reset,
  // cycle -1, straight from the scale table
  input  logic [2*`QT_TAIL_W-1:0]                  tail_set,
  input  logic [2*`QT_RANK_W-1:0]                  rank_set,
  input  quant_pkg::quant_mode_e                   mode,
  // cycle 0
  input  logic [`QT_ROW_W-1:0]                     add_bias_row,
  input  logic                                     row_valid,
  output logic [`QT_LANES-1:0][`QT_MULT_A_W-1:0]   mult_a,
  output logic [`QT_LANES-1:0][`QT_MULT_B_W-1:0]   mult_b,
  // cycle 1
  input  logic [`QT_LANES-1:0][`QT_MULT_P_W-1:0]   mult_p,
  output logic [`QT_QROW_W-1:0]                    quantized_row,
  output logic                                     quant_valid
);

  // meaningful product bits per mode
  localparam int field_88_w = `QT_PIX88_W + `QT_TAIL_W;
  localparam int field_18_w = `QT_PIX18_W + `QT_TAIL_W;
  localparam int sext_w = `QT_MULT_A_W - `QT_PIX18_W;

  logic [2*`QT_TAIL_W-1:0] tail_set_d1;
  logic [2*`QT_RANK_W-1:0] rank_set_d1;
  logic [2*`QT_RANK_W-1:0] rank_set_d2;

  //////////////////////////////////////////////////
  // scale set delay line
  //////////////////////////////////////////////////
  // tail lines up with the row at cycle 0
  // rank lines up with the products at cycle 1
  always_ff @(posedge clk) begin
    if (e_tail_reset) begin
      tail_set_d1 <= '0;
      rank_set_d1 <= '0;
      rank_set_d2 <= '0;
      quant_valid <= 1'b0;
    end else begin
      tail_set_d1 <= tail_set;
      rank_set_d1 <= rank_set;
      rank_set_d2 <= rank_set_d1;
      quant_valid <= row_valid;
    end
  end

  //////////////////////////////////////////////////
  // per lane operands and requantization
  //////////////////////////////////////////////////
  for (genvar i = 0; i < `QT_LANES; i++) begin : g_lane
    logic [`QT_PIX88_W-1:0] pix_88;
    logic [`QT_PIX18_W-1:0] pix_18;
    logic [`QT_TAIL_W-1:0]  lane_tail;
    logic [`QT_RANK_W-1:0]  lane_rank;
    logic                   lane_on;
    logic [field_88_w-1:0]  field_88;
    logic [field_18_w-1:0]  field_18;
    logic [field_88_w-1:0]  shift_88;
    logic [field_18_w-1:0]  shift_18;

    if (i < `QT_PIXELS) begin : g_low
      // channel 1, always active
      assign pix_88 = add_bias_row[i*`QT_PIX88_W +: `QT_PIX88_W];
      assign lane_tail = tail_set_d1[`QT_TAIL_W-1:0];
      assign lane_rank = rank_set_d2[`QT_RANK_W-1:0];
      assign lane_on = 1'b1;
    end else begin : g_high
      // channel 2, idle in mode_88
      assign pix_88 = '0;
      assign lane_tail = tail_set_d1[2*`QT_TAIL_W-1:`QT_TAIL_W];
      assign lane_rank = rank_set_d2[2*`QT_RANK_W-1:`QT_RANK_W];
      assign lane_on = (mode == quant_pkg::mode_18);
    end

    // 16-bit pixels are packed back to back over the whole row
    assign pix_18 = add_bias_row[i*`QT_PIX18_W +: `QT_PIX18_W];

    // cycle 0: sign extend in mode_18, pass through in mode_88
    assign mult_a[i] = (mode == quant_pkg::mode_18) ?
                       {{sext_w{pix_18[`QT_PIX18_W-1]}}, pix_18} : pix_88;
    assign mult_b[i] = lane_on ? lane_tail : '0;

    // cycle 1: relu on the field sign, then shift by rank
    assign field_88 = mult_p[i][field_88_w-1:0];
    assign field_18 = mult_p[i][field_18_w-1:0];
    assign shift_88 = field_88 >> lane_rank;
    assign shift_18 = field_18 >> lane_rank;

    // low 8 bits kept, no saturation
    always_comb begin
      if (!lane_on) begin
        quantized_row[i*`QT_QPIX_W +: `QT_QPIX_W] = '0;
      end else if (mode == quant_pkg::mode_18) begin
        quantized_row[i*`QT_QPIX_W +: `QT_QPIX_W] =
          field_18[field_18_w-1] ? '0 : shift_18[`QT_QPIX_W-1:0];
      end else begin
        quantized_row[i*`QT_QPIX_W +: `QT_QPIX_W] =
          field_88[field_88_w-1] ? '0 : shift_88[`QT_QPIX_W-1:0];
      end
    end
  end

endmodule

//--- design/scale_mult_lane.sv
`timescale 1ns/1ns
`include "quant_consts.svh"

module scale_mult_lane (
  input  logic                              clk,
  input  logic                              e_tail_reset,
  // pixel operand, already sign extended
  input  logic signed [`QT_MULT_A_W-1:0]    a,
  // scale tail, treated as unsigned
  input  logic [`QT_MULT_B_W-1:0]           b,
  output logic signed [`QT_MULT_P_W-1:0]    p
);

  logic signed [`QT_MULT_B_W:0]    b_ext;
  logic signed [`QT_MULT_P_W-1:0]  prod;

  //////////////////////////////////////////////////
  // signed x unsigned product
  //////////////////////////////////////////////////
  // extra zero bit keeps the tail positive
  assign b_ext = $signed({1'b0, b});

  // 24 x 17 signed fits in 40 bits for any non-negative tail
  assign prod = a * b_ext;

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////
  // product is visible on p one cycle after a and b
  always_ff @(posedge clk) begin
    if (e_tail_reset) begin
      p <= '0;
    end else begin
      p <= prod;
    end
  end

endmodule

//--- design/quant_tail_top.sv
`timescale 1ns/1ns
`include "quant_consts.svh"

module quant_tail_top (
  input  logic                              clk,
  input  logic                              e_tail_reset,
  // axi4-lite configuration port
  input  logic [`QT_AXI_ADDR_W-1:0]         awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [`QT_AXI_DATA_W-1:0]         wdata,
  input  logic [`QT_AXI_DATA_W/8-1:0]       wstrb,
  input  logic                              wvalid,
  output logic                              wready,
  output logic [1:0]                        bresp,
  output logic                              bvalid,
  input  logic                              bready,
  input  logic [`QT_AXI_ADDR_W-1:0]         araddr,
  input  logic                              arvalid,
  output logic                              arready,
  output logic [`QT_AXI_DATA_W-1:0]         rdata,
  output logic [1:0]                        rresp,
  output logic                              rvalid,
  input  logic                              rready,
  // pixel stream
  input  logic [`QT_TABLE_IDX_W-1:0]        channel_idx,
  input  logic [`QT_ROW_W-1:0]              add_bias_row,
  input  logic                              row_valid,
  output logic [`QT_QROW_W-1:0]             quantized_row,
  output logic                              quant_valid
);

  quant_pkg::quant_mode_e                  mode;
  logic [2*`QT_TAIL_W-1:0]                 tail_set;
  logic [2*`QT_RANK_W-1:0]                 rank_set;
  logic [`QT_LANES-1:0][`QT_MULT_A_W-1:0]  mult_a;
  logic [`QT_LANES-1:0][`QT_MULT_B_W-1:0]  mult_b;
  logic [`QT_LANES-1:0][`QT_MULT_P_W-1:0]  mult_p;

  //////////////////////////////////////////////////
  // mode register and scale table
  //////////////////////////////////////////////////
  scale_csr_axil u_csr (
    .clk, .e_tail_reset,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .channel_idx, .mode, .tail_set, .rank_set
  );

  // operand prep in front of the lanes, shift and relu behind them
  e_scale u_e_scale (
    .clk, .e_tail_reset,
    .tail_set, .rank_set, .mode,
    .add_bias_row, .row_valid,
    .mult_a, .mult_b, .mult_p,
    .quantized_row, .quant_valid
  );

  //////////////////////////////////////////////////
  // multiplier lanes
  //////////////////////////////////////////////////
  for (genvar g = 0; g < `QT_LANES; g++) begin : g_mult
    scale_mult_lane u_lane (
      .clk          (clk),
      .e_tail_reset (e_tail_reset),
      .a            (mult_a[g]),
      .b            (mult_b[g]),
      .p            (mult_p[g])
    );
  end

endmodule

//--- dv/quant_tail_assertions.sv
`timescale 1ns/1ns
`include "quant_consts.svh"

module quant_tail_assertions (
  input logic                    clk,
  input logic                    e_tail_reset,
  input logic                    awvalid,
  input logic                    awready,
  input logic                    wvalid,
  input logic                    wready,
  input logic                    arvalid,
  input logic                    arready,
  input logic                    bvalid,
  input logic                    bready,
  input logic [1:0]              bresp,
  input logic                    rvalid,
  input logic                    rready,
  input logic [1:0]              rresp,
  input logic [`QT_AXI_DATA_W-1:0] rdata,
  input logic                    row_valid,
  input logic                    quant_valid,
  input logic [`QT_QROW_W-1:0]   quantized_row,
  input quant_pkg::quant_mode_e  mode
);

  // failure tally, read by the testbench at the end
  int unsigned fails = 0;

  //////////////////////////////////////////////////
  // axi4-lite hold rules
  //////////////////////////////////////////////////
  assert property (@(posedge clk) disable iff (e_tail_reset)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      fails++;
      $error("write response dropped or changed before bready");
    end

  assert property (@(posedge clk) disable iff (e_tail_reset)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
      fails++;
      $error("read data dropped or changed before rready");
    end

  // a taken write answers next cycle, address and data wait meanwhile
  assert property (@(posedge clk) disable iff (e_tail_reset)
    awvalid && awready && wvalid && wready |=> bvalid && !awready && !wready)
    else begin
      fails++;
      $error("write taken without a response on the next cycle");
    end

  // a taken read returns data next cycle
  assert property (@(posedge clk) disable iff (e_tail_reset)
    arvalid && arready |=> rvalid && !arready)
    else begin
      fails++;
      $error("read taken without data on the next cycle");
    end

  // control outputs low right after a reset edge
  assert property (@(posedge clk)
    e_tail_reset |=> !quant_valid && !awready && !wready && !arready && !bvalid && !rvalid)
    else begin
      fails++;
      $error("control output high after reset");
    end

  //////////////////////////////////////////////////
  // pixel path timing and mode rules
  //////////////////////////////////////////////////
  assert property (@(posedge clk) disable iff (e_tail_reset)
    1'b1 |=> quant_valid == $past(row_valid))
    else begin
      fails++;
      $error("quant_valid does not follow row_valid by one cycle");
    end

  // one channel only, upper lanes idle
  assert property (@(posedge clk) disable iff (e_tail_reset)
    quant_valid && mode == quant_pkg::mode_88 |->
      quantized_row[`QT_QROW_W-1:`QT_QROW_W/2] == '0)
    else begin
      fails++;
      $error("upper half of quantized_row nonzero in mode_88");
    end

endmodule

bind quant_tail_top quant_tail_assertions u_checks (
  .clk, .e_tail_reset, .awvalid, .awready, .wvalid, .wready, .arvalid, .arready,
  .bvalid, .bready, .bresp, .rvalid, .rready, .rresp, .rdata,
  .row_valid, .quant_valid, .quantized_row, .mode
);

//--- dv/quant_tail_tb.sv
`timescale 1ns/1ns
`include "quant_consts.svh"

module quant_tail_tb;

  // rows per stream, random then all negative
  localparam int n_rows = 40;
  localparam int n_neg = 8;
  localparam int n_axi = 6 * `QT_TABLE_DEPTH + 16;
  // about 12 cycles per axi op, each stream plus its drain gap
  localparam int cycle_limit = 10 + 12 * n_axi + 2 * 2 * (n_rows + n_neg + 8) + 100;

  logic clk = 1'b0;
  logic e_tail_reset;
  logic [`QT_AXI_ADDR_W-1:0] awaddr;
  logic [`QT_AXI_ADDR_W-1:0] araddr;
  logic [`QT_AXI_DATA_W-1:0] wdata;
  logic [`QT_AXI_DATA_W-1:0] rdata;
  logic [3:0] wstrb;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [1:0] bresp, rresp;
  logic [`QT_TABLE_IDX_W-1:0] channel_idx;
  logic [`QT_ROW_W-1:0] add_bias_row;
  logic row_valid, quant_valid;
  logic [`QT_QROW_W-1:0] quantized_row;

  // software view of the scale table and mode
  logic [31:0] tail_tbl [`QT_TABLE_DEPTH];
  logic [15:0] rank_tbl [`QT_TABLE_DEPTH];
  quant_pkg::quant_mode_e mode_sw;
  logic [`QT_QROW_W-1:0] exp_q [$];
  int value_errors = 0;
  int unsigned cycles = 0;

  quant_tail_top dut (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("run stopped: not finished within %0d cycles", cycle_limit);
      $display("TEST FAIL");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (expected === actual) else begin
      value_errors++;
      $display("Error: %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  function automatic logic [7:0] model_pixel(input logic [`QT_ROW_W-1:0] row, input int lane,
                                             input logic [31:0] tails, input logic [15:0] ranks);
    logic signed [63:0] pix;
    logic signed [63:0] prod;
    logic [63:0] shifted;
    logic upper;
    upper = lane >= `QT_PIXELS;
    if (mode_sw == quant_pkg::mode_88 && upper) return 8'h00;
    if (mode_sw == quant_pkg::mode_88) pix = $signed(row[lane*24 +: 24]);
    else pix = $signed(row[lane*16 +: 16]);
    prod = pix * $signed({48'd0, upper ? tails[31:16] : tails[15:0]});
    // relu on the product sign
    if (prod < 0) return 8'h00;
    shifted = prod >> (upper ? ranks[15:8] : ranks[7:0]);
    return shifted[7:0];
  endfunction

  function automatic logic [`QT_QROW_W-1:0] model_row(input logic [`QT_ROW_W-1:0] row,
                                                      input logic [3:0] idx);
    logic [`QT_QROW_W-1:0] q;
    for (int i = 0; i < `QT_LANES; i++) begin
      q[i*8 +: 8] = model_pixel(row, i, tail_tbl[idx], rank_tbl[idx]);
    end
    return q;
  endfunction

  //////////////////////////////////////////////////
  // axi4-lite master
  //////////////////////////////////////////////////
  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int hold, input logic [1:0] exp_resp);
    @(negedge clk);
    awaddr = addr;
    wdata = data;
    wstrb = strb;
    awvalid = 1'b1;
    wvalid = 1'b1;
    while (!(awready && wready)) @(negedge clk);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
    while (!bvalid) @(negedge clk);
    // bready held low so bvalid must wait
    repeat (hold) @(negedge clk);
    check_value("bresp", exp_resp, bresp);
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [11:0] addr, input int hold,
                          input logic [31:0] exp_data, input logic [1:0] exp_resp);
    @(negedge clk);
    araddr = addr;
    arvalid = 1'b1;
    while (!arready) @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk);
    repeat (hold) @(negedge clk);
    check_value("rresp", exp_resp, rresp);
    if (exp_resp == 2'b00) check_value("rdata", exp_data, rdata);
    rready = 1'b1;
    @(negedge clk);
    rready = 0;
  endtask

  task automatic set_mode(input quant_pkg::quant_mode_e m);
    axi_write(`QT_ADDR_CTRL, {31'd0, m}, 4'h1, 1, 2'b00);
    mode_sw = m;
  endtask

  task automatic load_table(input int max_rank);
    for (int k = 0; k < `QT_TABLE_DEPTH; k++) begin
      tail_tbl[k] = $urandom;
      rank_tbl[k] = {8'($urandom_range(max_rank, 0)), 8'($urandom_range(max_rank, 0))};
      axi_write(`QT_ADDR_TAIL_BASE + 12'(4 * k), tail_tbl[k], 4'hf, k % 3, 2'b00);
      axi_write(`QT_ADDR_RANK_BASE + 12'(4 * k), {16'd0, rank_tbl[k]}, 4'hf, 0, 2'b00);
    end
  endtask

  //////////////////////////////////////////////////
  // pixel stream, channel_idx one cycle ahead
  //////////////////////////////////////////////////
  task automatic stream_rows(input int n, input bit neg_only);
    logic [`QT_ROW_W-1:0] row;
    @(negedge clk);
    channel_idx = 4'($urandom);
    for (int k = 0; k < n; k++) begin
      @(negedge clk);
      for (int w = 0; w < `QT_ROW_W / 32; w++) begin
        row[w*32 +: 32] = $urandom;
      end
      // sign bits of both pixel layouts
      for (int i = 0; i < `QT_LANES && neg_only; i++) begin
        row[i*16 + 15] = 1'b1;
        if (i < `QT_PIXELS) row[i*24 + 23] = 1'b1;
      end
      add_bias_row = row;
      row_valid = 1'b1;
      exp_q.push_back(model_row(row, channel_idx));
      // a different entry on every row
      channel_idx = channel_idx + 4'($urandom_range(15, 1));
    end
    @(negedge clk);
    row_valid = 1'b0;
    repeat (3) @(negedge clk);
  endtask

  always @(negedge clk) begin : out_check
    logic [`QT_QROW_W-1:0] expected;
    if (quant_valid && exp_q.size() == 0) begin
      value_errors++;
      $display("quant_valid high at %0t with no row in flight", $time);
    end else if (quant_valid) begin
      expected = exp_q.pop_front();
      for (int i = 0; i < `QT_LANES; i++) begin
        check_value($sformatf("quantized_row[%0d]", i), expected[i*8 +: 8],
                    quantized_row[i*8 +: 8]);
      end
    end
  end

  initial begin
    logic [31:0] patch;
    void'($urandom(32'had66_038b));
    {awaddr, awvalid, wdata, wstrb, wvalid, bready} = '0;
    {araddr, arvalid, rready, channel_idx, add_bias_row, row_valid} = '0;
    e_tail_reset = 1'b1;
    mode_sw = quant_pkg::mode_88;
    repeat (10) @(negedge clk);
    e_tail_reset = 1'b0;

    ////////////////////////////////////////////////
    // csr access
    ////////////////////////////////////////////////
    axi_read(`QT_ADDR_CTRL, 2, 32'd0, 2'b00);
    set_mode(quant_pkg::mode_18);
    axi_read(`QT_ADDR_CTRL, 5, 32'd1, 2'b00);
    load_table(39);
    for (int k = 0; k < `QT_TABLE_DEPTH; k++) begin
      axi_read(`QT_ADDR_TAIL_BASE + 12'(4 * k), k % 4, tail_tbl[k], 2'b00);
      axi_read(`QT_ADDR_RANK_BASE + 12'(4 * k), 0, {16'd0, rank_tbl[k]}, 2'b00);
    end
    // single byte lanes only
    patch = $urandom;
    axi_write(`QT_ADDR_TAIL_BASE + 12'd12, patch, 4'b0100, 0, 2'b00);
    tail_tbl[3][23:16] = patch[23:16];
    axi_read(`QT_ADDR_TAIL_BASE + 12'd12, 1, tail_tbl[3], 2'b00);
    axi_write(`QT_ADDR_RANK_BASE + 12'd20, {16'd0, 8'd7, 8'd99}, 4'b0010, 0, 2'b00);
    rank_tbl[5][15:8] = 8'd7;
    axi_read(`QT_ADDR_RANK_BASE + 12'd20, 0, {16'd0, rank_tbl[5]}, 2'b00);
    axi_write(12'h300, 32'hdead_beef, 4'hf, 3, 2'b10);
    axi_read(12'h300, 4, 32'd0, 2'b10);

    // mode_88 then mode_18, each with a relu pass
    set_mode(quant_pkg::mode_88);
    stream_rows(n_rows, 1'b0);
    stream_rows(n_neg, 1'b1);
    load_table(31);
    set_mode(quant_pkg::mode_18);
    stream_rows(n_rows, 1'b0);
    stream_rows(n_neg, 1'b1);

    if (exp_q.size() != 0) begin
      value_errors++;
      $display("%0d rows never produced quant_valid", exp_q.size());
    end
    $display("errors: %0d value checks, %0d assertion failures",
             value_errors, dut.u_checks.fails);
    if (value_errors == 0 && dut.u_checks.fails == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+design
design/quant_pkg.sv
design/scale_csr_axil.sv
design/e_scale.sv
design/scale_mult_lane.sv
design/quant_tail_top.sv
dv/quant_tail_assertions.sv
dv/quant_tail_tb.sv
